// ==== common/scratch_pkg.sv ====
// shared word, line, byte-enable and lane types, request and read-tag structs, line geometry
`default_nettype none

package scratch_pkg;

    ////////////////////////////////////////////////////////////
    // line geometry
    ////////////////////////////////////////////////////////////

    // one SRAM line holds four processor words side by side
    localparam int LINE_BITS = 128;

    // two address bits pick the word within a line
    localparam int LANE_BITS = 2;

    ////////////////////////////////////////////////////////////
    // word and line types
    ////////////////////////////////////////////////////////////

    // processor data word and its byte selects
    typedef logic [31:0] word_t;
    typedef logic [3:0]  word_be_t;

    // processor word address, byte offset already stripped off
    typedef logic [29:0] word_addr_t;

    // full SRAM line and one enable per line byte
    typedef logic [LINE_BITS-1:0]   line_t;
    typedef logic [LINE_BITS/8-1:0] line_be_t;

    // which word of the line an access refers to
    typedef logic [LANE_BITS-1:0] lane_t;

    ////////////////////////////////////////////////////////////
    // structs passed between blocks
    ////////////////////////////////////////////////////////////

    // processor request, only meaningful while the request strobe is high
    typedef struct packed {
        logic       we;
        word_addr_t addr;
        word_be_t   be;
        word_t      wdata;
    } word_req_t;

    // marks a read in flight and remembers which lane it wants back
    typedef struct packed {
        logic  pending;
        lane_t lane;
    } rd_tag_t;

endpackage

`default_nettype wire

// ==== hw/read_lane_select.sv ====
// read-side lane selector with held read data and read-valid pulse
`timescale 1ns/10ps
`default_nettype none

module read_lane_select
    import scratch_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  line_t   i_line,
    input  rd_tag_t i_rd_tag,
    output word_t   o_rdata,
    output logic    o_rvalid
);

    localparam int WORD_BITS = $bits(word_t);

    ////////////////////////////////////////////////////////////
    // lane mux
    ////////////////////////////////////////////////////////////

    word_t lane_word;
    word_t held_word;

    // the tag arrives in the same cycle as the registered SRAM line
    assign lane_word = i_line[i_rd_tag.lane*WORD_BITS +: WORD_BITS];

    // a read result is valid exactly while its tag is pending
    assign o_rvalid = i_rd_tag.pending;

    ////////////////////////////////////////////////////////////
    // held read data
    ////////////////////////////////////////////////////////////

    // the register only loads on a read result
    // so the zero line the SRAM returns on write cycles is never captured
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            held_word <= '0;
        end else if (i_rd_tag.pending) begin
            held_word <= lane_word;
        end
    end

    // during the valid cycle the fresh word is passed through
    // afterwards the held copy keeps the last result on the port
    assign o_rdata = i_rd_tag.pending ? lane_word : held_word;

endmodule

`default_nettype wire

// ==== hw/scratchpad_top.sv ====
// scratchpad top level joining the request decoder, byte-enabled SRAM and lane selector
`timescale 1ns/10ps
`default_nettype none

module scratchpad_top
    import scratch_pkg::*;
#(
    // line count is two to the power of this, 8 gives 256 lines or 4 KB
    parameter int LINE_ADDR_WIDTH = 8
) (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_req,
    input  word_req_t i_cmd,
    output word_t     o_rdata,
    output logic      o_rvalid,
    output logic      o_fault
);

    ////////////////////////////////////////////////////////////
    // internal wiring
    ////////////////////////////////////////////////////////////

    // decoder to SRAM, all combinational from the current request
    logic [LINE_ADDR_WIDTH-1:0] sram_addr;
    logic                       sram_we;
    line_be_t                   sram_be;
    line_t                      sram_wdata;

    // SRAM output and the matching tag, both one cycle after the request
    line_t   sram_rdata;
    rd_tag_t rd_tag;

    // request decode and range check
    word_access_decoder #(
        .LINE_ADDR_WIDTH(LINE_ADDR_WIDTH)
    ) u_decoder (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_req       (i_req),
        .i_cmd       (i_cmd),
        .o_sram_addr (sram_addr),
        .o_sram_we   (sram_we),
        .o_sram_be   (sram_be),
        .o_sram_wdata(sram_wdata),
        .o_rd_tag    (rd_tag),
        .o_fault     (o_fault)
    );

    // line storage, one full line per address
    generic_sram_byte_en #(
        .DATA_WIDTH   (LINE_BITS),
        .ADDRESS_WIDTH(LINE_ADDR_WIDTH)
    ) u_sram (
        .i_clk         (i_clk),
        .i_write_data  (sram_wdata),
        .i_write_enable(sram_we),
        .i_address     (sram_addr),
        .i_byte_enable (sram_be),
        .o_read_data   (sram_rdata)
    );

    // word extraction and read-valid generation
    read_lane_select u_lane_select (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_line  (sram_rdata),
        .i_rd_tag(rd_tag),
        .o_rdata (o_rdata),
        .o_rvalid(o_rvalid)
    );

endmodule

`default_nettype wire

// ==== hw/word_access_decoder.sv ====
// word-to-line request decoder with range check, registered fault pulse and read tag
`timescale 1ns/10ps
`default_nettype none

module word_access_decoder
    import scratch_pkg::*;
#(
    parameter int LINE_ADDR_WIDTH = 8
) (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_req,
    input  word_req_t                  i_cmd,
    output logic [LINE_ADDR_WIDTH-1:0] o_sram_addr,
    output logic                       o_sram_we,
    output line_be_t                   o_sram_be,
    output line_t                      o_sram_wdata,
    output rd_tag_t                    o_rd_tag,
    output logic                       o_fault
);

    // address bits that lie above the line index
    localparam int UPPER_LSB  = LANE_BITS + LINE_ADDR_WIDTH;
    localparam int UPPER_BITS = $bits(word_addr_t) - UPPER_LSB;

    // number of words in one line that the write word is copied into
    localparam int WORDS_PER_LINE = LINE_BITS / $bits(word_t);

    ////////////////////////////////////////////////////////////
    // address split and range check
    ////////////////////////////////////////////////////////////

    lane_t                      cmd_lane;
    logic [LINE_ADDR_WIDTH-1:0] cmd_line;
    logic [UPPER_BITS-1:0]      cmd_upper;
    logic                       out_of_range;
    logic                       req_ok;

    // the lowest word address bits pick the word inside the line
    assign cmd_lane  = i_cmd.addr[LANE_BITS-1:0];
    assign cmd_line  = i_cmd.addr[LANE_BITS +: LINE_ADDR_WIDTH];
    assign cmd_upper = i_cmd.addr[$bits(word_addr_t)-1:UPPER_LSB];

    // any set bit above the line index points past the end of the memory
    assign out_of_range = |cmd_upper;
    assign req_ok       = i_req & ~out_of_range;

    ////////////////////////////////////////////////////////////
    // SRAM drive straight from the current request
    ////////////////////////////////////////////////////////////

    assign o_sram_addr = cmd_line;

    // a faulting write must never reach the array
    assign o_sram_we = req_ok & i_cmd.we;

    // the four byte selects land on the bytes of the addressed lane
    // each lane is four bytes wide so the shift is the lane index times four
    assign o_sram_be = line_be_t'(i_cmd.be) << {cmd_lane, 2'b00};

    // every lane sees the same word and the byte enables choose where it lands
    assign o_sram_wdata = {WORDS_PER_LINE{i_cmd.wdata}};

    ////////////////////////////////////////////////////////////
    // registered fault pulse and read tag
    ////////////////////////////////////////////////////////////

    // both flags go high for exactly one cycle after the request edge
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_fault          <= 1'b0;
            o_rd_tag.pending <= 1'b0;
        end else begin
            o_fault          <= i_req & out_of_range;
            o_rd_tag.pending <= req_ok & ~i_cmd.we;
        end
    end

    // the lane of each request travels next to the pending bit to the lane selector
    always_ff @(posedge i_clk) begin
        o_rd_tag.lane <= cmd_lane;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# builds the scratchpad testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tb.f \
    --top-module tb_scratchpad \
    --Mdir obj_dir \
    -o tb_scratchpad_sim

if output=$(./obj_dir/tb_scratchpad_sim 2>&1); then
    sim_status=0
else
    sim_status=1
fi
printf '%s\n' "$output"

if [ "$sim_status" -eq 0 ] && printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// ==== sram/generic_sram_byte_en.sv ====
// synchronous single-port SRAM with per-byte write enable and registered read data
`timescale 1ns/10ps
`default_nettype none

module generic_sram_byte_en #(
    parameter int DATA_WIDTH    = 128,
    parameter int ADDRESS_WIDTH = 8
) (
    input  logic                      i_clk,
    input  logic [DATA_WIDTH-1:0]     i_write_data,
    input  logic                      i_write_enable,
    input  logic [ADDRESS_WIDTH-1:0]  i_address,
    input  logic [DATA_WIDTH/8-1:0]   i_byte_enable,
    output logic [DATA_WIDTH-1:0]     o_read_data
);

    // number of byte lanes in one memory line
    localparam int NUM_BYTES = DATA_WIDTH / 8;

    // number of lines held by the array
    localparam int DEPTH = 2 ** ADDRESS_WIDTH;

    ////////////////////////////////////////////////////////////
    // storage array
    ////////////////////////////////////////////////////////////

    // the array behaves like a memory macro and powers up undefined
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    ////////////////////////////////////////////////////////////
    // read and write port
    ////////////////////////////////////////////////////////////

    // a single port serves both directions on the same edge
    always_ff @(posedge i_clk) begin
        // the read data comes out one cycle after the address
        // a write cycle returns zero instead of the old line contents
        if (i_write_enable) begin
            o_read_data <= '0;
        end else begin
            o_read_data <= mem[i_address];
        end

        // only the bytes with their enable set are updated
        // the other bytes of the line keep their value so no read-modify-write is needed
        if (i_write_enable) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (i_byte_enable[b]) begin
                    mem[i_address][b*8 +: 8] <= i_write_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
common/scratch_pkg.sv
sram/generic_sram_byte_en.sv
hw/word_access_decoder.sv
hw/read_lane_select.sv
hw/scratchpad_top.sv
verification/scratchpad_properties.sv
verification/tb_scratchpad.sv

// ==== verification/scratchpad_properties.sv ====
// concurrent assertions on the scratchpad port timing, bound to the top level
`timescale 1ns/10ps
`default_nettype none

module scratchpad_properties
    import scratch_pkg::*;
#(
    parameter int LINE_ADDR_WIDTH = 8
) (
    input logic      i_clk,
    input logic      i_rst,
    input logic      i_req,
    input word_req_t i_cmd,
    input logic      o_rvalid,
    input logic      o_fault
);

    localparam int INDEX_BITS = LANE_BITS + LINE_ADDR_WIDTH;

    // a read whose upper address bits are all clear
    logic rd_req;
    assign rd_req = i_req & ~i_cmd.we & ~|i_cmd.addr[$bits(word_addr_t)-1:INDEX_BITS];

    ////////////////////////////////////////////////////////////
    // read timing
    ////////////////////////////////////////////////////////////

    // every in-range read is answered on the very next cycle, and nothing else is
    rvalid_after_read: assert property (@(posedge i_clk) disable iff (i_rst)
        rd_req |=> o_rvalid) else $error("o_rvalid missing after an in-range read");

    rvalid_needs_read: assert property (@(posedge i_clk) disable iff (i_rst)
        o_rvalid |-> $past(rd_req)) else $error("o_rvalid without a read the cycle before");

    ////////////////////////////////////////////////////////////
    // pulse exclusivity and reset
    ////////////////////////////////////////////////////////////

    // a request either faults or reads, never both
    fault_rvalid_apart: assert property (@(posedge i_clk)
        !(o_fault && o_rvalid)) else $error("o_fault and o_rvalid high together");

    quiet_after_reset: assert property (@(posedge i_clk)
        $past(i_rst) |-> (!o_rvalid && !o_fault)) else $error("pulse right after reset");

endmodule

bind scratchpad_top scratchpad_properties #(
    .LINE_ADDR_WIDTH(LINE_ADDR_WIDTH)
) u_properties (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_req   (i_req),
    .i_cmd   (i_cmd),
    .o_rvalid(o_rvalid),
    .o_fault (o_fault)
);

`default_nettype wire

// ==== verification/tb_scratchpad.sv ====
// directed testbench for the scratchpad with word model, compare tasks, LCG and timeout
`timescale 1ns/10ps
`default_nettype none

module tb_scratchpad
    import scratch_pkg::*;
();

    localparam int LINE_ADDR_WIDTH = 8;
    localparam int INDEX_BITS      = LINE_ADDR_WIDTH + LANE_BITS;
    localparam int WORD_COUNT      = 1 << INDEX_BITS;
    localparam int UPPER_BITS      = $bits(word_addr_t) - INDEX_BITS;
    localparam int NUM_TEST_WORDS  = 64;
    localparam int TEST_LINE       = 165;
    // the tests take about 500 cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES  = 5000;

    logic      i_clk;
    logic      i_rst;
    logic      i_req;
    word_req_t i_cmd;
    word_t     o_rdata;
    logic      o_rvalid;
    logic      o_fault;

    // reference model with one entry per in-range word address
    word_t      model_mem [WORD_COUNT];
    word_addr_t used_addr [NUM_TEST_WORDS];
    word_t      last_rdata;
    logic [31:0] rng_state;
    int data_errors = 0;
    int flag_errors = 0;
    int cycle_count = 0;

    scratchpad_top #(
        .LINE_ADDR_WIDTH(LINE_ADDR_WIDTH)
    ) dut (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_req   (i_req),
        .i_cmd   (i_cmd),
        .o_rdata (o_rdata),
        .o_rvalid(o_rvalid),
        .o_fault (o_fault)
    );

    always #5 i_clk = ~i_clk;

    // a run that never reaches its end is stopped here
    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // the low state bits of an LCG repeat quickly so the upper half is folded into them
    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state ^ (rng_state >> 16);
    endfunction

    // only the selected bytes take the new value
    function automatic word_t merge_bytes(word_t old_word, word_t new_word, word_be_t be);
        word_t result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                result[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic check_word(input word_t got, input word_t expected, input string what);
        if (got !== expected) begin
            data_errors++;
            $display("[FAIL] %0t: %s got %08h, expected %08h", $time, what, got, expected);
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            flag_errors++;
            $display("[FAIL] %0t: %s got %b, expected %b", $time, what, got, expected);
        end
    endtask

    // drives one request cycle and checks what the port shows after the edge
    task automatic access(input logic req, input logic we, input word_addr_t addr,
                          input word_be_t be, input word_t wdata);
        logic                  in_range;
        logic                  exp_valid;
        logic                  exp_fault;
        logic [INDEX_BITS-1:0] idx;
        in_range  = ~|addr[$bits(word_addr_t)-1:INDEX_BITS];
        idx       = addr[INDEX_BITS-1:0];
        exp_fault = req & ~in_range;
        exp_valid = req & in_range & ~we;
        i_req = req;
        i_cmd = '{we: we, addr: addr, be: be, wdata: wdata};
        // o_rdata keeps the last read result on idle, write and fault cycles
        if (exp_valid) begin
            last_rdata = model_mem[idx];
        end
        if (req && in_range && we) begin
            model_mem[idx] = merge_bytes(model_mem[idx], wdata, be);
        end
        @(posedge i_clk);
        #1;
        check_flag(o_rvalid, exp_valid, $sformatf("o_rvalid after access to %08h", addr));
        check_flag(o_fault, exp_fault, $sformatf("o_fault after access to %08h", addr));
        check_word(o_rdata, last_rdata, $sformatf("o_rdata after access to %08h", addr));
    endtask

    task automatic write_word(input word_addr_t addr, input word_be_t be, input word_t data);
        access(1'b1, 1'b1, addr, be, data);
    endtask

    task automatic read_word(input word_addr_t addr);
        access(1'b1, 1'b0, addr, '0, '0);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        check_flag(o_rvalid, 1'b0, "o_rvalid after reset");
        check_flag(o_fault, 1'b0, "o_fault after reset");
        check_word(o_rdata, '0, "o_rdata after reset");
        repeat (4) access(1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic test_full_words();
        logic [31:0] r;
        for (int i = 0; i < NUM_TEST_WORDS; i++) begin
            r = lcg_next();
            used_addr[i] = '0;
            used_addr[i][INDEX_BITS-1:0] = r[INDEX_BITS-1:0];
            write_word(used_addr[i], 4'hf, lcg_next());
            read_word(used_addr[i]);
        end
    endtask

    task automatic test_partial_bytes();
        logic [31:0] r;
        for (int i = 0; i < NUM_TEST_WORDS; i++) begin
            r = lcg_next();
            write_word(used_addr[r[5:0]], r[11:8], lcg_next());
            read_word(used_addr[r[5:0]]);
        end
    endtask

    // single bytes land in the neighbour lane while each word is checked
    task automatic test_lane_independence();
        for (int k = 0; k < 4; k++) begin
            write_word(word_addr_t'(TEST_LINE * 4 + k), 4'hf, {4{8'(8'h10 + k)}});
        end
        for (int k = 0; k < 4; k++) begin
            write_word(word_addr_t'(TEST_LINE * 4 + (k + 1) % 4), 4'b0001 << k, 32'heeeeeeee);
            read_word(word_addr_t'(TEST_LINE * 4 + k));
        end
        for (int k = 0; k < 4; k++) begin
            read_word(word_addr_t'(TEST_LINE * 4 + k));
        end
    endtask

    task automatic test_back_to_back();
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            read_word(used_addr[i]);
        end
        for (int i = 0; i < 120; i++) begin
            r = lcg_next();
            if (r[9:8] == 2'b00) begin
                write_word(used_addr[r[5:0]], r[15:12], lcg_next());
            end else begin
                read_word(used_addr[r[5:0]]);
            end
        end
    endtask

    // a set upper bit aliases onto an in-range word that must stay untouched
    task automatic test_out_of_range();
        logic [31:0] r;
        word_addr_t  bad;
        int          bit_pos;
        for (int i = 0; i < 16; i++) begin
            r = lcg_next();
            bad = used_addr[r[5:0]];
            bit_pos = INDEX_BITS + int'(r[20:16]) % UPPER_BITS;
            bad[bit_pos] = 1'b1;
            if (i % 2 == 0) begin
                write_word(bad, 4'hf, lcg_next());
            end else begin
                read_word(bad);
            end
            read_word(used_addr[r[5:0]]);
        end
    endtask

    initial begin
        i_clk      = 1'b0;
        i_rst      = 1'b1;
        i_req      = 1'b0;
        i_cmd      = '0;
        last_rdata = '0;
        rng_state  = 32'hde563c5a;
        repeat (3) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        test_reset_state();
        test_full_words();
        test_partial_bytes();
        test_lane_independence();
        test_back_to_back();
        test_out_of_range();
        access(1'b0, 1'b0, '0, '0, '0);
        $display("errors: %0d data, %0d flag", data_errors, flag_errors);
        if (data_errors == 0 && flag_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
